//--- flist.f
hw/memPkg.sv
hw/slowMemory.sv
hw/cacheController.sv
hw/cacheRegs.sv
hw/memSubsystem.sv
verif/memSubsystem_asserts.sv
verif/memSubsystemTb.sv

//--- hw/cacheController.sv
`default_nettype none

module cacheController
  import memPkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  memReq_t      cpuReq,
  output memResp_t     cpuResp,
  output memReq_t      memReq,
  input  memResp_t     memResp,
  input  cacheCtrl_t   cacheCtrl,
  output cacheEvents_t cacheEvents
);

  cacheState_t state;
  cacheState_t nextState;

  // line storage
  tag_t                  tagArr  [CacheLines];
  word_t                 dataArr [CacheLines][LineWords];
  logic [CacheLines-1:0] validArr;

  lineIdx_t lineIdx;
  wordOff_t wordOff;
  tag_t     reqTag;
  logic     lineHit;
  logic     directAccess;
  logic     useCache;
  logic     flushPending;
  logic     flushNow;
  wordOff_t fillOff;
  logic     fillLast;

  // request fields, stable for the whole access
  assign lineIdx = cpuReq.addr[7:4];
  assign wordOff = cpuReq.addr[3:2];
  assign reqTag  = cpuReq.addr[13:8];
  assign lineHit = validArr[lineIdx] && (tagArr[lineIdx] == reqTag);

  // writes and bypassed reads make a single memory access
  assign directAccess = cpuReq.we || (cpuReq.re && !cacheCtrl.enable);

  // a pulse seen in IDLE acts at once, otherwise it waits
  assign flushNow = cacheCtrl.flush || flushPending;
  assign fillLast = (fillOff == wordOff_t'(LineWords - 1));

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= CACHE_IDLE;
    else
      state <= nextState;
  end

  always_comb
  begin
    nextState = state;
    case (state)
      CACHE_IDLE:
        if (directAccess)
          nextState = CACHE_WRITE;
        else if (cpuReq.re)
          nextState = CACHE_LOOKUP;
      CACHE_LOOKUP:
        nextState = lineHit ? CACHE_RESPOND : CACHE_FILL;
      CACHE_FILL:
        // whole line in before answering
        if (memResp.valid && fillLast)
          nextState = CACHE_RESPOND;
      CACHE_WRITE:
        // also carries bypassed reads
        if (memResp.valid)
          nextState = CACHE_IDLE;
      CACHE_RESPOND:
        nextState = CACHE_IDLE;
      default:
        nextState = CACHE_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      flushPending <= 1'b0;
      validArr     <= '0;
      fillOff      <= '0;
      useCache     <= 1'b0;
    end
    else
    begin
      // remember a flush that arrives mid-access
      if (state == CACHE_IDLE)
        flushPending <= 1'b0;
      else if (cacheCtrl.flush)
        flushPending <= 1'b1;
      // invalidate everything, or mark a completed fill
      if (state == CACHE_IDLE && flushNow)
        validArr <= '0;
      else if (state == CACHE_FILL && memResp.valid && fillLast)
        validArr[lineIdx] <= 1'b1;
      // fill always starts at word 0
      if (state == CACHE_LOOKUP)
        fillOff <= '0;
      else if (state == CACHE_FILL && memResp.valid)
        fillOff <= fillOff + 1'b1;
      // enable sampled once per access
      if (state == CACHE_IDLE)
        useCache <= cacheCtrl.enable;
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == CACHE_FILL && memResp.valid)
    begin
      dataArr[lineIdx][fillOff] <= memResp.rdata;
      if (fillLast)
        tagArr[lineIdx] <= reqTag;
    end
    // write-through, resident word kept in step
    if (state == CACHE_WRITE && memResp.valid && cpuReq.we && useCache && lineHit)
      dataArr[lineIdx][wordOff] <= cpuReq.wdata;
  end

  // memory side
  always_comb
  begin
    memReq = '0;
    case (state)
      CACHE_IDLE:
        // forwarded in the same cycle, bypass latency stays at one access
        if (directAccess)
          memReq = cpuReq;
      CACHE_WRITE:
        memReq = cpuReq;
      CACHE_FILL:
      begin
        memReq.re   = 1'b1;
        memReq.addr = {cpuReq.addr[31:4], fillOff, 2'b00};
      end
      default:
        memReq = '0;
    endcase
  end

  // processor side
  assign cpuResp.valid = (state == CACHE_RESPOND) || (state == CACHE_WRITE && memResp.valid);
  assign cpuResp.rdata = (state == CACHE_RESPOND) ? dataArr[lineIdx][wordOff] : memResp.rdata;

  // events only from a cached read lookup
  assign cacheEvents.hit  = (state == CACHE_LOOKUP) && lineHit;
  assign cacheEvents.miss = (state == CACHE_LOOKUP) && !lineHit;

endmodule

`default_nettype wire

//--- hw/cacheRegs.sv
`default_nettype none

module cacheRegs
  import memPkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  axiLiteReq_t  axiReq,
  output axiLiteResp_t axiResp,
  output cacheCtrl_t   cacheCtrl,
  input  cacheEvents_t cacheEvents
);

  logic       wrFire;
  logic       rdFire;
  logic       wrMapped;
  logic       rdMapped;
  logic       bvalidReg;
  logic       rvalidReg;
  logic [1:0] brespReg;
  logic [1:0] rrespReg;
  word_t      rdataReg;
  word_t      rdMux;
  logic       enableReg;
  logic       flushReg;
  logic       clearHits;
  logic       clearMisses;
  count_t     hitCount;
  count_t     missCount;

  // address and data taken together, one response in flight
  assign wrFire = axiReq.awvalid && axiReq.wvalid && !bvalidReg;
  assign rdFire = axiReq.arvalid && !rvalidReg;

  assign wrMapped = (axiReq.awaddr == RegCtrl) || (axiReq.awaddr == RegHits) ||
                    (axiReq.awaddr == RegMisses);

  // any write to a counter clears it
  assign clearHits   = wrFire && (axiReq.awaddr == RegHits);
  assign clearMisses = wrFire && (axiReq.awaddr == RegMisses);

  // read decode, unmapped reads give 0
  always_comb
  begin
    rdMux    = '0;
    rdMapped = 1'b1;
    case (axiReq.araddr)
      RegCtrl:
        // flush always reads back 0
        rdMux = {30'b0, 1'b0, enableReg};
      RegHits:
        rdMux = hitCount;
      RegMisses:
        rdMux = missCount;
      default:
        rdMapped = 1'b0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      enableReg <= 1'b0;
      flushReg  <= 1'b0;
      bvalidReg <= 1'b0;
      rvalidReg <= 1'b0;
    end
    else
    begin
      // cache starts in bypass
      if (wrFire && axiReq.awaddr == RegCtrl)
        enableReg <= axiReq.wdata[0];
      // write-one flush becomes a single pulse
      flushReg <= wrFire && (axiReq.awaddr == RegCtrl) && axiReq.wdata[1];
      // responses hold until accepted
      if (wrFire)
        bvalidReg <= 1'b1;
      else if (axiReq.bready)
        bvalidReg <= 1'b0;
      if (rdFire)
        rvalidReg <= 1'b1;
      else if (axiReq.rready)
        rvalidReg <= 1'b0;
    end
  end

  // response payload
  always_ff @(posedge clk)
  begin
    if (wrFire)
      brespReg <= wrMapped ? AxiRespOkay : AxiRespSlvErr;
    if (rdFire)
    begin
      rdataReg <= rdMux;
      rrespReg <= rdMapped ? AxiRespOkay : AxiRespSlvErr;
    end
  end

  // clear wins over a same-cycle event
  always_ff @(posedge clk)
  begin
    if (reset || clearHits)
      hitCount <= '0;
    else if (cacheEvents.hit)
      hitCount <= hitCount + 1'b1;
    if (reset || clearMisses)
      missCount <= '0;
    else if (cacheEvents.miss)
      missCount <= missCount + 1'b1;
  end

  assign axiResp.awready = wrFire;
  assign axiResp.wready  = wrFire;
  assign axiResp.bvalid  = bvalidReg;
  assign axiResp.bresp   = brespReg;
  assign axiResp.arready = rdFire;
  assign axiResp.rvalid  = rvalidReg;
  assign axiResp.rdata   = rdataReg;
  assign axiResp.rresp   = rrespReg;

  assign cacheCtrl.enable = enableReg;
  assign cacheCtrl.flush  = flushReg;

endmodule

`default_nettype wire

//--- hw/memPkg.sv
`default_nettype none

package memPkg;

  // backing memory timing and depth
  localparam int MemWaitCycles = 3;
  localparam int MemWords = 4096;
  // accepting edge to valid pulse
  localparam int MemLatency = MemWaitCycles + 2;

  // direct-mapped cache geometry
  localparam int LineWords = 4;
  localparam int CacheLines = 16;

  // address and data widths
  typedef logic [31:0] byteAddr_t;
  typedef logic [31:0] word_t;
  // byte address bits 13:2
  typedef logic [11:0] wordIdx_t;
  // bits 7:4
  typedef logic [3:0] lineIdx_t;
  // bits 3:2
  typedef logic [1:0] wordOff_t;
  // bits 13:8
  typedef logic [5:0] tag_t;
  typedef logic [31:0] count_t;
  typedef logic [3:0] regAddr_t;
  // wait counter inside the backing memory
  typedef logic [$clog2(MemLatency)-1:0] memCount_t;

  // register map
  localparam regAddr_t RegCtrl = 4'h0;
  localparam regAddr_t RegHits = 4'h4;
  localparam regAddr_t RegMisses = 4'h8;

  // axi4-lite response codes
  localparam logic [1:0] AxiRespOkay = 2'b00;
  localparam logic [1:0] AxiRespSlvErr = 2'b10;

  // request side, held until valid
  typedef struct packed {
    logic re;
    logic we;
    byteAddr_t addr;
    word_t wdata;
  } memReq_t;

  typedef struct packed {
    logic valid;
    word_t rdata;
  } memResp_t;

  // master-driven axi4-lite signals
  typedef struct packed {
    logic awvalid;
    regAddr_t awaddr;
    logic wvalid;
    word_t wdata;
    logic [3:0] wstrb;
    logic bready;
    logic arvalid;
    regAddr_t araddr;
    logic rready;
  } axiLiteReq_t;

  // slave-driven axi4-lite signals
  typedef struct packed {
    logic awready;
    logic wready;
    logic bvalid;
    logic [1:0] bresp;
    logic arready;
    logic rvalid;
    word_t rdata;
    logic [1:0] rresp;
  } axiLiteResp_t;

  // flush is a single-cycle pulse
  typedef struct packed {
    logic enable;
    logic flush;
  } cacheCtrl_t;

  typedef struct packed {
    logic hit;
    logic miss;
  } cacheEvents_t;

  typedef enum logic [1:0] {MEM_IDLE, MEM_REQUESTED, MEM_RETRIEVED} memState_t;

  typedef enum logic [2:0] {
    CACHE_IDLE,
    CACHE_LOOKUP,
    CACHE_FILL,
    CACHE_WRITE,
    CACHE_RESPOND
  } cacheState_t;

endpackage

`default_nettype wire

//--- hw/memSubsystem.sv
`default_nettype none

module memSubsystem
  import memPkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  memReq_t      cpuReq,
  output memResp_t     cpuResp,
  input  axiLiteReq_t  axiReq,
  output axiLiteResp_t axiResp
);

  // cache to backing memory
  memReq_t      memReq;
  memResp_t     memResp;
  // register block steering and event feedback
  cacheCtrl_t   cacheCtrl;
  cacheEvents_t cacheEvents;

  // axi4-lite control and counters
  cacheRegs i_regs (
    .clk         (clk),
    .reset       (reset),
    .axiReq      (axiReq),
    .axiResp     (axiResp),
    .cacheCtrl   (cacheCtrl),
    .cacheEvents (cacheEvents)
  );

  // direct-mapped write-through cache
  cacheController i_cache (
    .clk         (clk),
    .reset       (reset),
    .cpuReq      (cpuReq),
    .cpuResp     (cpuResp),
    .memReq      (memReq),
    .memResp     (memResp),
    .cacheCtrl   (cacheCtrl),
    .cacheEvents (cacheEvents)
  );

  // fixed-delay word memory
  slowMemory i_memory (
    .clk     (clk),
    .reset   (reset),
    .memReq  (memReq),
    .memResp (memResp)
  );

endmodule

`default_nettype wire

//--- hw/slowMemory.sv
`default_nettype none

module slowMemory
  import memPkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  memReq_t  memReq,
  output memResp_t memResp
);

  memState_t state;
  memState_t nextState;
  memCount_t waitCount;
  logic      waitDone;
  wordIdx_t  wordIdx;
  word_t     rdataReg;
  word_t     mem [MemWords];

  // upper and lowest two address bits dropped
  assign wordIdx = memReq.addr[13:2];

  // last REQUESTED cycle before the response
  assign waitDone = (state == MEM_REQUESTED) && (waitCount == memCount_t'(MemLatency - 1));

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= MEM_IDLE;
    else
      state <= nextState;
  end

  // counts cycles spent waiting
  // restarts whenever the memory leaves REQUESTED
  always_ff @(posedge clk)
  begin
    if (reset || state != MEM_REQUESTED)
      waitCount <= '0;
    else
      waitCount <= waitCount + 1'b1;
  end

  always_comb
  begin
    nextState = state;
    case (state)
      MEM_IDLE:
        // requests are only taken here
        if (memReq.re || memReq.we)
          nextState = MEM_REQUESTED;
      MEM_REQUESTED:
        if (waitDone)
          nextState = MEM_RETRIEVED;
      MEM_RETRIEVED:
        nextState = MEM_IDLE;
      default:
        nextState = MEM_IDLE;
    endcase
  end

  // write lands on the accepting edge
  // read data sampled as valid rises, the request is still held
  always_ff @(posedge clk)
  begin
    if (state == MEM_IDLE && memReq.we)
      mem[wordIdx] <= memReq.wdata;
    if (waitDone)
      rdataReg <= mem[wordIdx];
  end

  // single-cycle valid out of RETRIEVED
  assign memResp.valid = (state == MEM_RETRIEVED);
  assign memResp.rdata = rdataReg;

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module memSubsystemTb -Mdir obj_dir -f flist.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

# keep running after an assertion error so the testbench reports it
./obj_dir/VmemSubsystemTb +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi

exit 0

//--- verif/memSubsystemTb.sv
`default_nettype none

module memSubsystemTb
  import memPkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TimeoutCycles = 2000;
  localparam int WindowWords = 512;
  localparam int EnabledOps = 3000;
  localparam int LatencyReads = 64;

  logic         clk;
  logic         reset;
  memReq_t      cpuReq;
  memResp_t     cpuResp;
  axiLiteReq_t  axiReq;
  axiLiteResp_t axiResp;

  // reference memory image
  word_t  modelMem [MemWords];
  // tag and valid copy for hit prediction
  tag_t   modelTag [CacheLines];
  logic   modelValid [CacheLines];
  logic   modelEnable;
  count_t expHits;
  count_t expMisses;

  memSubsystem i_dut (
    .clk     (clk),
    .reset   (reset),
    .cpuReq  (cpuReq),
    .cpuResp (cpuResp),
    .axiReq  (axiReq),
    .axiResp (axiResp)
  );

  // 10 ns clock
  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stopWithFail();
    $display("TEST FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic checkWord(input word_t got, input word_t exp, input string what);
    if (got !== exp)
    begin
      $display("[FAIL] %0d ns: %s, expected %h, got %h", $time, what, exp, got);
      stopWithFail();
    end
  endtask

  task automatic checkCount(input count_t got, input count_t exp, input string what);
    if (got !== exp)
    begin
      $display("[FAIL] %0d ns: %s, expected %0d, got %0d", $time, what, exp, got);
      stopWithFail();
    end
  endtask

  task automatic checkResp(input logic [1:0] got, input logic [1:0] exp, input string what);
    if (got !== exp)
    begin
      $display("[FAIL] %0d ns: %s, expected %b, got %b", $time, what, exp, got);
      stopWithFail();
    end
  endtask

  // one processor access, held until valid, cycles counted from the drive edge
  task automatic cpuAccess(input logic isWrite, input byteAddr_t addr, input word_t wdata,
                           output word_t rdata, output int cycles);
    memReq_t req;
    req       = '0;
    req.re    = !isWrite;
    req.we    = isWrite;
    req.addr  = addr;
    req.wdata = wdata;
    @(posedge clk);
    cpuReq <= req;
    cycles = 0;
    forever
    begin
      @(negedge clk);
      if (cpuResp.valid)
        break;
      cycles++;
      if (cycles >= TimeoutCycles)
      begin
        $display("timeout: no processor response at %0d ns", $time);
        stopWithFail();
      end
    end
    rdata = cpuResp.rdata;
    // dropped on the edge after valid
    @(posedge clk);
    cpuReq <= '0;
  endtask

  // axi4-lite write, address and data together
  task automatic regWrite(input regAddr_t addr, input word_t data, output logic [1:0] resp);
    int waited;
    @(posedge clk);
    axiReq.awvalid <= 1'b1;
    axiReq.awaddr  <= addr;
    axiReq.wvalid  <= 1'b1;
    axiReq.wdata   <= data;
    axiReq.wstrb   <= 4'hf;
    axiReq.bready  <= 1'b1;
    waited = 0;
    forever
    begin
      @(negedge clk);
      if (axiResp.awready && axiResp.wready)
        break;
      waited++;
      if (waited >= TimeoutCycles)
      begin
        $display("timeout: register write was never accepted at %0d ns", $time);
        stopWithFail();
      end
    end
    @(posedge clk);
    axiReq.awvalid <= 1'b0;
    axiReq.wvalid  <= 1'b0;
    waited = 0;
    forever
    begin
      @(negedge clk);
      if (axiResp.bvalid)
        break;
      waited++;
      if (waited >= TimeoutCycles)
      begin
        $display("timeout: no write response at %0d ns", $time);
        stopWithFail();
      end
    end
    resp = axiResp.bresp;
    @(posedge clk);
    axiReq.bready <= 1'b0;
  endtask

  task automatic regRead(input regAddr_t addr, output word_t data, output logic [1:0] resp);
    int waited;
    @(posedge clk);
    axiReq.arvalid <= 1'b1;
    axiReq.araddr  <= addr;
    axiReq.rready  <= 1'b1;
    waited = 0;
    forever
    begin
      @(negedge clk);
      if (axiResp.arready)
        break;
      waited++;
      if (waited >= TimeoutCycles)
      begin
        $display("timeout: register read was never accepted at %0d ns", $time);
        stopWithFail();
      end
    end
    @(posedge clk);
    axiReq.arvalid <= 1'b0;
    waited = 0;
    forever
    begin
      @(negedge clk);
      if (axiResp.rvalid)
        break;
      waited++;
      if (waited >= TimeoutCycles)
      begin
        $display("timeout: no read response at %0d ns", $time);
        stopWithFail();
      end
    end
    data = axiResp.rdata;
    resp = axiResp.rresp;
    @(posedge clk);
    axiReq.rready <= 1'b0;
  endtask

  // counter readback with an OKAY response
  task automatic expectCount(input regAddr_t addr, input count_t exp, input string what);
    word_t      data;
    logic [1:0] resp;
    regRead(addr, data, resp);
    checkResp(resp, AxiRespOkay, what);
    checkCount(count_t'(data), exp, what);
  endtask

  // random upper and byte bits, they must be ignored
  function automatic byteAddr_t placeAddr(input wordIdx_t idx);
    byteAddr_t a;
    a       = $urandom;
    a[13:2] = idx;
    return a;
  endfunction

  // direct-mapped lookup, a miss allocates the line
  task automatic modelLookup(input byteAddr_t addr);
    lineIdx_t idx;
    tag_t     tag;
    idx = addr[7:4];
    tag = addr[13:8];
    if (modelEnable)
    begin
      if (modelValid[idx] && modelTag[idx] == tag)
        expHits++;
      else
      begin
        expMisses++;
        modelValid[idx] = 1'b1;
        modelTag[idx]   = tag;
      end
    end
  endtask

  task automatic readAndCheck(input byteAddr_t addr);
    word_t data;
    int    cycles;
    modelLookup(addr);
    cpuAccess(1'b0, addr, '0, data, cycles);
    checkWord(data, modelMem[addr[13:2]], "read data");
  endtask

  // write-through, no allocation and no event
  task automatic writeWord(input byteAddr_t addr, input word_t data);
    word_t unused;
    int    cycles;
    cpuAccess(1'b1, addr, data, unused, cycles);
    modelMem[addr[13:2]] = data;
  endtask

  initial
  begin
    word_t      data;
    logic [1:0] resp;
    int         cycles;
    byteAddr_t  addr;
    regAddr_t   off;
    count_t     hitsBefore;
    byteAddr_t  flushed [$];

    void'($urandom(32'h3e57));
    reset  <= 1'b1;
    cpuReq <= '0;
    axiReq <= '0;
    modelEnable = 1'b0;
    expHits     = '0;
    expMisses   = '0;
    for (int i = 0; i < CacheLines; i++)
      modelValid[i] = 1'b0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    // bypass, every word written before any read
    for (int i = 0; i < MemWords; i++)
      writeWord(placeAddr(wordIdx_t'(i)), word_t'($urandom));
    for (int i = 0; i < MemWords; i++)
      readAndCheck(placeAddr(wordIdx_t'(i)));
    expectCount(RegHits, '0, "hit counter in bypass");
    expectCount(RegMisses, '0, "miss counter in bypass");

    // enabled traffic in a 512-word window
    regWrite(RegCtrl, 32'h1, resp);
    checkResp(resp, AxiRespOkay, "enable write response");
    modelEnable = 1'b1;
    for (int n = 0; n < EnabledOps; n++)
    begin
      addr = placeAddr(wordIdx_t'($urandom % WindowWords));
      if ($urandom % 4 == 0)
        writeWord(addr, word_t'($urandom));
      else
        readAndCheck(addr);
    end
    expectCount(RegHits, expHits, "hit counter after traffic");
    expectCount(RegMisses, expMisses, "miss counter after traffic");

    // write to a resident word, then read it back
    addr = placeAddr(wordIdx_t'($urandom % WindowWords));
    readAndCheck(addr);
    writeWord(addr, word_t'($urandom));
    hitsBefore = expHits;
    readAndCheck(addr);
    expectCount(RegHits, hitsBefore + count_t'(1), "hit after write-through");

    // remember the resident lines, then flush
    flushed.delete();
    for (int i = 0; i < CacheLines; i++)
    begin
      if (modelValid[i])
      begin
        addr       = byteAddr_t'($urandom);
        addr[13:8] = modelTag[i];
        addr[7:4]  = lineIdx_t'(i);
        flushed.push_back(addr);
      end
    end
    regWrite(RegCtrl, 32'h3, resp);
    checkResp(resp, AxiRespOkay, "flush write response");
    for (int i = 0; i < CacheLines; i++)
      modelValid[i] = 1'b0;
    regRead(RegCtrl, data, resp);
    checkResp(resp, AxiRespOkay, "control read response");
    checkWord(data, 32'h1, "control readback after flush");

    // any write clears a counter
    regWrite(RegHits, 32'h0, resp);
    checkResp(resp, AxiRespOkay, "hit clear response");
    regWrite(RegMisses, 32'hffff_ffff, resp);
    checkResp(resp, AxiRespOkay, "miss clear response");
    expHits   = '0;
    expMisses = '0;
    expectCount(RegHits, '0, "hit counter after clear");
    expectCount(RegMisses, '0, "miss counter after clear");
    foreach (flushed[k])
      readAndCheck(flushed[k]);
    expectCount(RegMisses, count_t'(flushed.size()), "misses after flush");
    expectCount(RegHits, '0, "hits after flush");
    regWrite(RegMisses, 32'h1, resp);
    checkResp(resp, AxiRespOkay, "second miss clear response");
    expectCount(RegMisses, '0, "nonzero miss counter cleared");

    // unmapped offsets give SLVERR and read 0
    for (int a = 0; a < 16; a++)
    begin
      off = regAddr_t'(a);
      if (off != RegCtrl && off != RegHits && off != RegMisses)
      begin
        regRead(off, data, resp);
        checkResp(resp, AxiRespSlvErr, "unmapped read response");
        checkWord(data, '0, "unmapped read data");
        regWrite(off, word_t'($urandom), resp);
        checkResp(resp, AxiRespSlvErr, "unmapped write response");
      end
    end

    // bypass latency, one memory access per read
    regWrite(RegCtrl, 32'h0, resp);
    checkResp(resp, AxiRespOkay, "disable write response");
    modelEnable = 1'b0;
    for (int n = 0; n < LatencyReads; n++)
    begin
      addr = placeAddr(wordIdx_t'($urandom % MemWords));
      cpuAccess(1'b0, addr, '0, data, cycles);
      checkWord(data, modelMem[addr[13:2]], "bypass read data");
      checkCount(count_t'(cycles), count_t'(MemLatency + 1), "bypass read latency");
    end
    expectCount(RegHits, '0, "hits during bypass latency reads");

    // bound handshake checks
    if (i_dut.i_cache.i_asserts.failCount == 0)
    begin
      $display("TEST PASS");
      $finish;
    end
    else
    begin
      $display("handshake assertions failed %0d times",
               i_dut.i_cache.i_asserts.failCount);
      stopWithFail();
    end
  end

endmodule

`default_nettype wire

//--- verif/memSubsystem_asserts.sv
`default_nettype none

module memSubsystem_asserts
  import memPkg::*;
(
  input logic     clk,
  input logic     reset,
  input memReq_t  cpuReq,
  input memResp_t cpuResp,
  input memReq_t  memReq,
  input memResp_t memResp
);

  timeunit 1ns;
  timeprecision 1ps;

  // read by the testbench at the end of the run
  int failCount = 0;

  // processor response is a single-cycle pulse
  respPulse: assert property (@(posedge clk) disable iff (reset)
    cpuResp.valid |=> !cpuResp.valid)
  else
  begin
    $error("cpuResp.valid stayed high for more than one cycle");
    failCount++;
  end

  // memory request held until its valid arrives
  memReqHeld: assert property (@(posedge clk) disable iff (reset)
    (memReq.re || memReq.we) && !memResp.valid |=> $stable(memReq))
  else
  begin
    $error("memReq changed before memResp.valid");
    failCount++;
  end

  // read and write never together on either port
  oneCommand: assert property (@(posedge clk) disable iff (reset)
    !(cpuReq.re && cpuReq.we) && !(memReq.re && memReq.we))
  else
  begin
    $error("re and we high in the same cycle");
    failCount++;
  end

endmodule

// attached to every cache controller
bind cacheController memSubsystem_asserts i_asserts (
  .clk     (clk),
  .reset   (reset),
  .cpuReq  (cpuReq),
  .cpuResp (cpuResp),
  .memReq  (memReq),
  .memResp (memResp)
);

`default_nettype wire
